//--- pet_defines.svh
/*
 * PET bus core widths and slot timing
 * One CPU period is 2**PET_SLOT_BITS system clocks, split into a
 * Wishbone window and a CPU window
 */
`ifndef PET_DEFINES_SVH
`define PET_DEFINES_SVH

`define PET_DATA_WIDTH      8
`define PET_CPU_ADDR_WIDTH  16
`define PET_RAM_ADDR_WIDTH  17
`define PET_WB_ADDR_WIDTH   17

// 16 system clocks per CPU clock
`define PET_SLOT_BITS       4
`define PET_WB_LAST_SLOT    4
`define PET_CPU_FIRST_SLOT  8

`endif

//--- bus_pkg.sv
/*
 * Bus types shared by the Wishbone RAM controller and the top level
 * Captured Wishbone request, SRAM drive and controller state
 */
`include "pet_defines.svh"

package bus_pkg;

    typedef struct packed {
        logic [`PET_WB_ADDR_WIDTH-1:0] addr;
        logic [`PET_DATA_WIDTH-1:0]    data;
        logic                          we;
    } wb_req_t;

    // What the controller puts on the SRAM side of the board
    typedef struct packed {
        logic [`PET_RAM_ADDR_WIDTH-1:0] addr;
        logic                           oe;
        logic                           we;
        logic [`PET_DATA_WIDTH-1:0]     data;
        logic                           data_oe;
    } sram_ctl_t;

    typedef enum logic [1:0] {
        RAM_IDLE,
        RAM_READ,
        RAM_WRITE,
        RAM_ACK
    } ram_state_e;

endpackage

//--- map_pkg.sv
/*
 * PET memory map types
 * Region codes and the per-address decode result
 */
package map_pkg;

    typedef enum logic [2:0] {
        REG_RAM,
        REG_VIDEO,
        REG_ROM,
        REG_IO,
        REG_NONE
    } region_e;

    typedef struct packed {
        region_e region;
        logic    ram_en;
        logic    pia1_en;
        logic    pia2_en;
        logic    via_en;
        logic    io_en;
        logic    readonly;
    } decode_t;

endpackage

//--- bus_timing.sv
/*
 * Slot timing
 * Free-running slot counter that opens the Wishbone window at the start
 * of each CPU period and the CPU window in its second half
 */
`timescale 1ns/100ps
`include "pet_defines.svh"

module bus_timing (
    input  logic wb_clock_i,
    input  logic rst_ni,
    output logic wb_grant_o,
    output logic cpu_grant_o
);
    localparam logic [`PET_SLOT_BITS-1:0] wb_last_slot =
        `PET_SLOT_BITS'(`PET_WB_LAST_SLOT);
    localparam logic [`PET_SLOT_BITS-1:0] cpu_first_slot =
        `PET_SLOT_BITS'(`PET_CPU_FIRST_SLOT);

    logic [`PET_SLOT_BITS-1:0] slot_q;

    // Grants lag the counter by one clock so they come straight from flops
    always_ff @(posedge wb_clock_i or negedge rst_ni) begin
        if (!rst_ni) begin
            slot_q      <= '0;
            wb_grant_o  <= 1'b0;
            cpu_grant_o <= 1'b0;
        end else begin
            slot_q      <= slot_q + 1'b1;
            wb_grant_o  <= (slot_q <= wb_last_slot);
            cpu_grant_o <= (slot_q >= cpu_first_slot);
        end
    end

    // Guard slots between the windows keep the two owners apart
    assert property (@(posedge wb_clock_i) disable iff (!rst_ni)
        $fell(wb_grant_o) |-> !cpu_grant_o [*3])
        else $error("CPU grant inside the guard slots");

endmodule

//--- cpu_clock_gen.sv
/*
 * CPU bus enable and clock
 * Bus enable follows the CPU grant by one clock; the CPU clock is high
 * in the second half of each bus-enable window
 */
`timescale 1ns/100ps
`include "pet_defines.svh"

module cpu_clock_gen (
    input  logic wb_clock_i,
    input  logic rst_ni,
    input  logic cpu_grant_i,
    output logic cpu_be_o,
    output logic cpu_clock_o
);
    // 8 cycles of bus enable per CPU period
    localparam int unsigned be_cycles = (1 << `PET_SLOT_BITS) - `PET_CPU_FIRST_SLOT;
    localparam int unsigned cnt_bits  = $clog2(be_cycles);
    localparam logic [cnt_bits-1:0] clk_start = cnt_bits'(be_cycles / 2 - 1);

    logic [cnt_bits-1:0] be_cnt_q;

    always_ff @(posedge wb_clock_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cpu_be_o    <= 1'b0;
            cpu_clock_o <= 1'b0;
            be_cnt_q    <= '0;
        end else begin
            cpu_be_o <= cpu_grant_i;
            be_cnt_q <= cpu_be_o ? be_cnt_q + 1'b1 : '0;
            // Grant drops one clock ahead of bus enable, ending the high phase
            cpu_clock_o <= cpu_grant_i && cpu_be_o && (be_cnt_q >= clk_start);
        end
    end

    assert property (@(posedge wb_clock_i) disable iff (!rst_ni)
        cpu_clock_o |-> cpu_be_o)
        else $error("CPU clock high outside bus enable");

endmodule

//--- wb_ram_ctl.sv
/*
 * Wishbone to SRAM controller
 * Pipelined Wishbone peripheral that runs one SRAM read or write per
 * accepted request and acks two clocks after acceptance
 */
`timescale 1ns/100ps
`include "pet_defines.svh"

module wb_ram_ctl
    import bus_pkg::*;
(
    input  logic                       wb_clock_i,
    input  logic                       rst_ni,
    input  logic                       wb_cycle_i,
    input  logic                       wb_strobe_i,
    input  wb_req_t                    wb_req_i,
    output logic [`PET_DATA_WIDTH-1:0] wb_data_o,
    output logic                       wb_stall_o,
    output logic                       wb_ack_o,
    output sram_ctl_t                  sram_o,
    input  logic [`PET_DATA_WIDTH-1:0] ram_data_i
);
    ram_state_e state_q;
    ram_state_e state_d;
    wb_req_t    req_q;
    logic       accept;
    logic       wr_strobe;

    assign accept = wb_cycle_i && wb_strobe_i && (state_q == RAM_IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            RAM_IDLE: begin
                if (accept) begin
                    state_d = wb_req_i.we ? RAM_WRITE : RAM_READ;
                end
            end
            RAM_READ:  state_d = RAM_ACK;
            RAM_WRITE: state_d = RAM_ACK;
            default:   state_d = RAM_IDLE;
        endcase
    end

    always_ff @(posedge wb_clock_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= RAM_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request and read data registers
    always_ff @(posedge wb_clock_i) begin
        if (accept) begin
            req_q <= wb_req_i;
        end
        if (state_q == RAM_READ) begin
            wb_data_o <= ram_data_i;
        end
    end

    // Write strobe lands in the ack cycle, data is already settled
    assign wr_strobe = (state_q == RAM_ACK) && req_q.we;

    always_comb begin
        sram_o.addr    = req_q.addr;
        sram_o.oe      = (state_q == RAM_READ);
        sram_o.we      = wr_strobe;
        sram_o.data    = req_q.data;
        sram_o.data_oe = (state_q == RAM_WRITE) || wr_strobe;
    end

    assign wb_stall_o = (state_q != RAM_IDLE);
    assign wb_ack_o   = (state_q == RAM_ACK);

    assert property (@(posedge wb_clock_i) disable iff (!rst_ni)
        !(sram_o.oe && sram_o.we))
        else $error("SRAM oe and we both high");

    assert property (@(posedge wb_clock_i) disable iff (!rst_ni)
        wb_ack_o |=> !wb_ack_o)
        else $error("Ack wider than one clock");

endmodule

//--- address_decoder.sv
/*
 * PET address decoder
 * Maps a CPU address onto RAM, video RAM, ROM image and the I/O page
 * with its PIA1, PIA2 and VIA selects
 */
`timescale 1ns/100ps
`include "pet_defines.svh"

module address_decoder
    import map_pkg::*;
(
    input  logic [`PET_CPU_ADDR_WIDTH-1:0] addr_i,
    output decode_t                        decode_o
);
    always_comb begin
        decode_o          = '0;
        decode_o.region   = REG_NONE;

        if (!addr_i[15]) begin
            // 0000-7FFF
            decode_o.region = REG_RAM;
            decode_o.ram_en = 1'b1;
        end else if (addr_i[15:12] == 4'h8) begin
            // 8000-8FFF
            decode_o.region = REG_VIDEO;
            decode_o.ram_en = 1'b1;
        end else if (addr_i[15:8] == 8'hE8) begin
            // I/O page never reaches the SRAM
            decode_o.region  = REG_IO;
            decode_o.io_en   = 1'b1;
            decode_o.pia1_en = (addr_i[7:4] == 4'h1);
            decode_o.pia2_en = (addr_i[7:4] == 4'h2);
            decode_o.via_en  = (addr_i[7:4] == 4'h4);
        end else begin
            // ROM image lives in SRAM, read only
            decode_o.region   = REG_ROM;
            decode_o.ram_en   = 1'b1;
            decode_o.readonly = 1'b1;
        end
    end

endmodule

//--- pet_system.sv
/*
 * PET bus core top level
 * Shares one SRAM between a Wishbone peripheral and the CPU by time
 * slot, and decodes the CPU side of the memory map
 */
`timescale 1ns/100ps
`include "pet_defines.svh"

module pet_system
    import bus_pkg::*;
    import map_pkg::*;
(
    // Wishbone B4 pipelined peripheral
    input  logic                          wb_clock_i,
    input  logic                          rst_ni,
    input  logic [`PET_WB_ADDR_WIDTH-1:0] wb_addr_i,
    input  logic [`PET_DATA_WIDTH-1:0]    wb_data_i,
    output logic [`PET_DATA_WIDTH-1:0]    wb_data_o,
    input  logic                          wb_we_i,
    input  logic                          wb_cycle_i,
    input  logic                          wb_strobe_i,
    output logic                          wb_stall_o,
    output logic                          wb_ack_o,

    // CPU
    output logic                           cpu_reset_o,
    output logic                           cpu_be_o,
    output logic                           cpu_ready_o,
    output logic                           cpu_clock_o,
    output logic                           cpu_irq_o,
    output logic                           cpu_nmi_o,
    input  logic [`PET_CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    output logic [`PET_CPU_ADDR_WIDTH-1:0] cpu_addr_o,
    output logic                           cpu_addr_oe,
    input  logic [`PET_DATA_WIDTH-1:0]     cpu_data_i,
    output logic [`PET_DATA_WIDTH-1:0]     cpu_data_o,
    output logic                           cpu_data_oe,
    input  logic                           cpu_we_i,
    output logic                           cpu_we_oe,

    // RAM
    output logic ram_addr_a10_o,
    output logic ram_addr_a11_o,
    output logic ram_addr_a15_o,
    output logic ram_addr_a16_o,
    output logic ram_oe_o,
    output logic ram_we_o,

    // I/O
    output logic io_oe_o,
    output logic pia1_cs_o,
    output logic pia2_cs_o,
    output logic via_cs_o
);
    logic      wb_grant;
    logic      cpu_grant;
    logic      ctl_strobe;
    logic      ctl_stall;
    wb_req_t   wb_req;
    sram_ctl_t sram;
    decode_t   decode;
    logic      cpu_rd_strobe;
    logic      cpu_wr_strobe;

    // CPU controls held inactive, RWB always driven by the CPU
    assign cpu_ready_o = 1'b1;
    assign cpu_reset_o = 1'b0;
    assign cpu_irq_o   = 1'b0;
    assign cpu_nmi_o   = 1'b0;
    assign cpu_we_oe   = 1'b0;

    bus_timing timing0 (
        .wb_clock_i (wb_clock_i),
        .rst_ni     (rst_ni),
        .wb_grant_o (wb_grant),
        .cpu_grant_o(cpu_grant)
    );

    cpu_clock_gen cpu_clk0 (
        .wb_clock_i (wb_clock_i),
        .rst_ni     (rst_ni),
        .cpu_grant_i(cpu_grant),
        .cpu_be_o   (cpu_be_o),
        .cpu_clock_o(cpu_clock_o)
    );

    // Wishbone only reaches the controller inside its window
    assign ctl_strobe = wb_grant && wb_strobe_i;
    assign wb_stall_o = !wb_grant || ctl_stall;
    assign wb_req     = '{addr: wb_addr_i, data: wb_data_i, we: wb_we_i};

    wb_ram_ctl ram_ctl0 (
        .wb_clock_i (wb_clock_i),
        .rst_ni     (rst_ni),
        .wb_cycle_i (wb_cycle_i),
        .wb_strobe_i(ctl_strobe),
        .wb_req_i   (wb_req),
        .wb_data_o  (wb_data_o),
        .wb_stall_o (ctl_stall),
        .wb_ack_o   (wb_ack_o),
        .sram_o     (sram),
        .ram_data_i (cpu_data_i)
    );

    address_decoder decoder0 (
        .addr_i  (cpu_addr_i),
        .decode_o(decode)
    );

    assign cpu_rd_strobe = cpu_be_o && !cpu_we_i;
    // ROM region takes no CPU writes
    assign cpu_wr_strobe = cpu_be_o && cpu_we_i && cpu_clock_o && !decode.readonly;

    assign io_oe_o   = decode.io_en && cpu_be_o;
    assign pia1_cs_o = decode.pia1_en && cpu_be_o;
    assign pia2_cs_o = decode.pia2_en && cpu_be_o;
    assign via_cs_o  = decode.via_en && cpu_be_o;

    assign ram_oe_o = (cpu_rd_strobe && decode.ram_en) || sram.oe;
    assign ram_we_o = (cpu_wr_strobe && decode.ram_en) || sram.we;

    assign cpu_addr_o  = sram.addr[15:0];
    assign cpu_addr_oe = !cpu_be_o;
    assign cpu_data_o  = sram.data;
    assign cpu_data_oe = sram.data_oe;

    // Upper SRAM address bits not wired through the CPU bus
    assign ram_addr_a10_o = cpu_be_o ? cpu_addr_i[10] : sram.addr[10];
    assign ram_addr_a11_o = cpu_be_o ? cpu_addr_i[11] : sram.addr[11];
    assign ram_addr_a15_o = cpu_be_o ? cpu_addr_i[15] : sram.addr[15];
    assign ram_addr_a16_o = cpu_be_o ? 1'b0 : sram.addr[16];

    assert property (@(posedge wb_clock_i) disable iff (!rst_ni)
        cpu_be_o |-> !(ctl_stall || sram.oe))
        else $error("CPU bus enable during a Wishbone transfer");

    assert property (@(posedge wb_clock_i) disable iff (!rst_ni)
        !(io_oe_o && sram.oe))
        else $error("I/O output enable during a Wishbone read");

endmodule

//--- tb_pet_system.sv
/*
 * Testbench for the PET bus core
 * Random Wishbone writes and reads against an SRAM model, random CPU
 * addresses in the CPU window, checked by concurrent assertions
 */
`timescale 1ns/100ps
`include "pet_defines.svh"

module tb_pet_system;
    localparam int clk_period   = 40;
    localparam int reset_cycles = 10;
    localparam int n_pairs      = 24;
    localparam int n_xfer       = 2 * n_pairs;
    localparam logic [31:0] rng_seed = 32'hdcb5_9bca;

    logic                           wb_clock_i;
    logic                           rst_ni;
    logic [`PET_WB_ADDR_WIDTH-1:0]  wb_addr_i;
    logic [`PET_DATA_WIDTH-1:0]     wb_data_i;
    logic [`PET_DATA_WIDTH-1:0]     wb_data_o;
    logic                           wb_we_i;
    logic                           wb_cycle_i;
    logic                           wb_strobe_i;
    logic                           wb_stall_o;
    logic                           wb_ack_o;
    logic                           cpu_reset_o;
    logic                           cpu_be_o;
    logic                           cpu_ready_o;
    logic                           cpu_clock_o;
    logic                           cpu_irq_o;
    logic                           cpu_nmi_o;
    logic [`PET_CPU_ADDR_WIDTH-1:0] cpu_addr_i;
    logic [`PET_CPU_ADDR_WIDTH-1:0] cpu_addr_o;
    logic                           cpu_addr_oe;
    logic [`PET_DATA_WIDTH-1:0]     cpu_data_i;
    logic [`PET_DATA_WIDTH-1:0]     cpu_data_o;
    logic                           cpu_data_oe;
    logic                           cpu_we_i;
    logic                           cpu_we_oe;
    logic                           ram_addr_a10_o;
    logic                           ram_addr_a11_o;
    logic                           ram_addr_a15_o;
    logic                           ram_addr_a16_o;
    logic                           ram_oe_o;
    logic                           ram_we_o;
    logic                           io_oe_o;
    logic                           pia1_cs_o;
    logic                           pia2_cs_o;
    logic                           via_cs_o;

    logic [7:0]  sram_mem [0:(1 << `PET_RAM_ADDR_WIDTH)-1];
    logic [7:0]  shadow   [0:(1 << `PET_RAM_ADDR_WIDTH)-1];
    logic [16:0] wr_addr  [0:n_pairs-1];
    logic [16:0] sram_addr;
    logic [31:0] wb_rng;
    logic [31:0] cpu_rng;
    logic [7:0]  exp_rdata;
    logic        accepted;
    logic [3:0]  ref_slot;
    logic        phase_valid;

    pet_system dut0 (.*);

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic flag_mismatch(input string msg);
        $display("Mismatch at %0d ns: %s", $time, msg);
        abort_run();
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected {io, pia1, pia2, via} from the PET map ranges
    function automatic logic [3:0] io_selects(input logic [15:0] a);
        logic io;
        io = (a >= 16'hE800) && (a <= 16'hE8FF);
        return {io,
                (a >= 16'hE810) && (a <= 16'hE81F),
                (a >= 16'hE820) && (a <= 16'hE82F),
                (a >= 16'hE840) && (a <= 16'hE84F)};
    endfunction

    function automatic logic is_rom(input logic [15:0] a);
        return (a >= 16'h9000) && !((a >= 16'hE800) && (a <= 16'hE8FF));
    endfunction

    function automatic logic is_ram(input logic [15:0] a);
        return a <= 16'h8FFF;
    endfunction

    initial begin
        wb_clock_i = 1'b0;
        forever #(clk_period / 2) wb_clock_i = ~wb_clock_i;
    end

    // Reference slot of the grant flops reads 0 on the first edge after reset
    always @(posedge wb_clock_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ref_slot    <= 4'hF;
            phase_valid <= 1'b0;
        end else begin
            ref_slot    <= ref_slot + 4'd1;
            phase_valid <= phase_valid || (ref_slot == 4'd1);
        end
    end

    // SRAM model owned by the controller whenever the CPU address is released
    assign sram_addr  = {ram_addr_a16_o, cpu_addr_o};
    assign cpu_data_i = (ram_oe_o && cpu_addr_oe) ? sram_mem[sram_addr] : 8'h00;

    always @(posedge wb_clock_i) begin
        if (ram_we_o && cpu_addr_oe && cpu_data_oe) begin
            sram_mem[sram_addr] <= cpu_data_o;
        end
    end

    assign accepted = wb_cycle_i && wb_strobe_i && !wb_stall_o;

    // Bus enable in slots 9..15 and 0 with the CPU clock in the last four of them
    assert property (@(posedge wb_clock_i) disable iff (!rst_ni)
        phase_valid |-> cpu_be_o == (ref_slot >= 4'd9 || ref_slot == 4'd0))
        else flag_mismatch("cpu_be_o out of phase with the slot count");

    assert property (@(posedge wb_clock_i) disable iff (!rst_ni)
        phase_valid |-> cpu_clock_o == (ref_slot >= 4'd13 || ref_slot == 4'd0))
        else flag_mismatch("cpu_clock_o out of phase with bus enable");

    assert property (@(posedge wb_clock_i) disable iff (!rst_ni)
        wb_ack_o == $past(accepted, 2))
        else flag_mismatch("ack not exactly 2 cycles after acceptance");

    assert property (@(posedge wb_clock_i) disable iff (!rst_ni)
        (wb_ack_o && !$past(wb_we_i, 2)) |-> wb_data_o == $past(exp_rdata, 2))
        else flag_mismatch("Wishbone read data differs from the last write");

    // Slot 0 overlaps the last bus-enable cycle and its SRAM access starts one later
    assert property (@(posedge wb_clock_i) disable iff (!rst_ni)
        (phase_valid && cpu_be_o && ref_slot != 4'd0) |-> wb_stall_o)
        else flag_mismatch("wb_stall_o low inside the CPU window");

    assert property (@(posedge wb_clock_i) disable iff (!rst_ni)
        accepted |=> !cpu_be_o)
        else flag_mismatch("Wishbone transfer runs while cpu_be_o is high");

    assert property (@(posedge wb_clock_i) disable iff (!rst_ni)
        {io_oe_o, pia1_cs_o, pia2_cs_o, via_cs_o}
            == (cpu_be_o ? io_selects(cpu_addr_i) : 4'b0000))
        else flag_mismatch("I/O selects differ from the memory map");

    // CPU reads enable the SRAM everywhere except the I/O page
    assert property (@(posedge wb_clock_i) disable iff (!rst_ni)
        cpu_be_o |-> ram_oe_o == (!cpu_we_i && (is_ram(cpu_addr_i) || is_rom(cpu_addr_i))))
        else flag_mismatch("ram_oe_o differs from the memory map on a CPU read");

    assert property (@(posedge wb_clock_i) disable iff (!rst_ni)
        (cpu_be_o && cpu_we_i && is_rom(cpu_addr_i)) |-> !ram_we_o)
        else flag_mismatch("ram_we_o raised by a CPU write to ROM");

    assert property (@(posedge wb_clock_i) disable iff (!rst_ni)
        (cpu_be_o && cpu_we_i && is_ram(cpu_addr_i)) |-> ram_we_o == cpu_clock_o)
        else flag_mismatch("ram_we_o does not follow cpu_clock_o on a RAM write");

    assert property (@(posedge wb_clock_i) disable iff (!rst_ni)
        cpu_be_o |-> (!cpu_addr_oe && ram_addr_a10_o == cpu_addr_i[10]
                      && ram_addr_a11_o == cpu_addr_i[11]
                      && ram_addr_a15_o == cpu_addr_i[15] && !ram_addr_a16_o))
        else flag_mismatch("RAM address bits not taken from the CPU");

    // Outside the CPU window the controller address drives the SRAM
    assert property (@(posedge wb_clock_i) disable iff (!rst_ni)
        !cpu_be_o |-> (cpu_addr_oe && ram_addr_a10_o === cpu_addr_o[10]
                       && ram_addr_a11_o === cpu_addr_o[11]
                       && ram_addr_a15_o === cpu_addr_o[15]))
        else flag_mismatch("RAM address bits not taken from the controller");

    // CPU control pins stay at their inactive levels
    assert property (@(posedge wb_clock_i) disable iff (!rst_ni)
        {cpu_reset_o, cpu_ready_o, cpu_irq_o, cpu_nmi_o, cpu_we_oe} == 5'b01000)
        else flag_mismatch("CPU control outputs not at their inactive levels");

    task automatic wb_transfer(input logic [16:0] addr, input logic we, input logic [7:0] data);
        @(negedge wb_clock_i);
        wb_addr_i   = addr;
        wb_data_i   = data;
        wb_we_i     = we;
        wb_cycle_i  = 1'b1;
        wb_strobe_i = 1'b1;
        exp_rdata   = shadow[addr];
        // Hold the request until a rising edge sees stall low
        while (wb_stall_o) begin
            @(negedge wb_clock_i);
        end
        @(negedge wb_clock_i);
        wb_strobe_i = 1'b0;
        while (!wb_ack_o) begin
            @(negedge wb_clock_i);
        end
        wb_cycle_i = 1'b0;
    endtask

    // Random CPU addresses biased toward the I/O page and the ROM image
    initial begin
        cpu_rng = {rng_seed[15:0], rng_seed[31:16]};
        @(posedge rst_ni);
        forever begin
            @(negedge wb_clock_i);
            cpu_rng  = xorshift32(cpu_rng);
            cpu_we_i = cpu_rng[20];
            case (cpu_rng[17:16])
                2'd0:    cpu_addr_i = cpu_rng[15:0];
                2'd1:    cpu_addr_i = {8'hE8, cpu_rng[7:0]};
                2'd2:    cpu_addr_i = {4'hF, cpu_rng[11:0]};
                default: cpu_addr_i = {1'b0, cpu_rng[14:0]};
            endcase
        end
    end

    initial begin
        #(clk_period * (reset_cycles + n_xfer * 32 + 200));
        $display("Timeout at %0d ns: Wishbone transfers did not finish in time", $time);
        abort_run();
    end

    initial begin
        logic [7:0] data;
        rst_ni      = 1'b0;
        wb_addr_i   = '0;
        wb_data_i   = '0;
        wb_we_i     = 1'b0;
        wb_cycle_i  = 1'b0;
        wb_strobe_i = 1'b0;
        cpu_addr_i  = '0;
        cpu_we_i    = 1'b0;
        exp_rdata   = '0;
        wb_rng      = rng_seed;
        repeat (reset_cycles) @(negedge wb_clock_i);
        rst_ni = 1'b1;

        for (int i = 0; i < n_pairs; i++) begin
            wb_rng     = xorshift32(wb_rng);
            wr_addr[i] = wb_rng[16:0];
            data       = wb_rng[31:24];
            shadow[wr_addr[i]] = data;
            wb_transfer(wr_addr[i], 1'b1, data);
        end
        for (int i = 0; i < n_pairs; i++) begin
            wb_transfer(wr_addr[i], 1'b0, 8'h00);
        end

        // A few more periods of CPU traffic
        repeat (64) @(negedge wb_clock_i);
        $display("sim passed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
bus_pkg.sv
map_pkg.sv
bus_timing.sv
cpu_clock_gen.sv
wb_ram_ctl.sv
address_decoder.sv
pet_system.sv
tb_pet_system.sv

//--- Makefile
# Verilator lint and simulation of the PET bus core

VERILATOR  ?= verilator
FILELIST   ?= verilog.f
TB_TOP     ?= tb_pet_system
RTL_TOP    ?= pet_system
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert
EXTRA_ARGS ?=

SOURCES := $(wildcard *.sv *.svh)
SIM_EXE := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(EXTRA_ARGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) $(EXTRA_ARGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR)

# A $fatal in the testbench gives a non-zero exit status
sim: $(SIM_EXE)
	./$(SIM_EXE)

clean:
	rm -rf $(BUILD_DIR)
